// ==== hw/mips_isa_pkg.sv ====
// MIPS subset instruction encodings
package mips_isa_pkg;

    // Primary opcodes kept in the subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000, // Function field selects the operation
        OP_J     = 6'b000010, // Jump
        OP_JAL   = 6'b000011, // Jump and link to r31
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTIU = 6'b001011, // Sign extended imm, unsigned compare
        OP_ANDI  = 6'b001100, // Zero extended imm
        OP_ORI   = 6'b001101, // Zero extended imm
        OP_XORI  = 6'b001110, // Zero extended imm
        OP_LUI   = 6'b001111, // Imm into upper half
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // Function codes for OP_RTYPE
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000, // Jump to rs
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010, // Signed compare
        FN_SLTU = 6'b101011  // Unsigned compare
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;    // First source
        logic [4:0] rt;    // Second source
        logic [4:0] rd;    // Destination
        logic [4:0] shamt; // Unused by the subset
        funct_t     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;  // Base or first source
        logic [4:0]  rt;  // Destination or store data
        logic [15:0] imm; // Immediate or branch offset
    } i_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target; // Word index within the 256 MB region
    } j_fmt_t;

    // Same 32-bit word seen in all three formats
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage

// ==== hw/cpu_ctrl_pkg.sv ====
// Core control types
package cpu_ctrl_pkg;

    // Sequencer states
    typedef enum logic [3:0] {
        HALT   = 4'd0, // Run finished
        FETCH  = 4'd1, // Read instruction at PC
        DECODE = 4'd2, // Load instruction register
        EXEC1  = 4'd3, // ALU work, LW read
        EXEC2  = 4'd4  // Writeback, SW write, PC update
    } cpu_state_t;

    // Operation performed by the ALU
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLT  = 3'd5,
        ALU_SLTU = 3'd6,
        ALU_LUI  = 3'd7  // Second operand shifted up 16
    } alu_op_t;

    // Coarse ALU class from the main decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00, // Address and ADDIU
        ALUOP_SUB   = 2'b01, // Branch compare
        ALUOP_FUNCT = 2'b10, // R-type function field
        ALUOP_IMM   = 2'b11  // Immediate logic by opcode
    } aluop_class_t;

    // Control word from control_unit to the datapath
    typedef struct packed {
        aluop_class_t aluop;
        logic         alusrc;    // Second operand from immediate
        logic         imm_zext;  // Zero extend the immediate
        logic         jump;      // Take jump target
        logic         branch;    // Conditional branch
        logic         branch_ne; // Branch on not equal
        logic         regtojump; // Jump target from rs
        logic         link;      // Write PC+4 to r31
        logic         memread;   // Avalon read strobe
        logic         memwrite;  // Avalon write strobe
        logic         pctoadd;   // Address from PC
        logic         regdst;    // Destination is rd
        logic         memtoreg;  // Writeback from readdata
        logic         regwrite;  // Register file write
        logic         inwrite;   // Instruction register load
        logic         pcwrite;   // PC update
    } ctrl_t;

endpackage

// ==== hw/cpu_sequencer.sv ====
// Multicycle state sequencer
`timescale 1ns/1ps

module cpu_sequencer #(
    parameter logic [31:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     waitrequest,
    input  logic                     memread,
    input  logic                     memwrite,
    input  logic                     jump_zero,
    output cpu_ctrl_pkg::cpu_state_t state,
    output logic                     active
);
    import cpu_ctrl_pkg::*;

    cpu_state_t state_next;
    logic       stall;

    // Start address must be word aligned
    if (RESET_VECTOR[1:0] != 2'b00) begin : g_bad_vector
        $error("RESET_VECTOR is not word aligned");
    end

    assign stall = (memread || memwrite) && waitrequest; // Request still pending

    always_comb begin
        state_next = state; // Hold by default
        case (state)
            FETCH: begin
                if (!stall) begin
                    state_next = DECODE;
                end
            end
            DECODE: state_next = EXEC1; // Always one cycle
            EXEC1: begin
                if (!stall) begin // Only LW reads here
                    state_next = EXEC2;
                end
            end
            EXEC2: begin
                if (!stall) begin // Only SW writes here
                    state_next = jump_zero ? HALT : FETCH;
                end
            end
            HALT:    state_next = HALT; // Stays until reset
            default: state_next = HALT; // Illegal encoding
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    assign active = (state != HALT);

    // One Avalon strobe at a time from the decoder
    a_no_read_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(memread && memwrite))
        else $error("memread and memwrite high together");

    // Halted core stays off the bus
    a_halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (state == HALT) |-> !memread && !memwrite)
        else $error("bus strobe while halted");

endmodule

// ==== hw/control_unit.sv ====
// Main opcode and state decoder
`timescale 1ns/1ps

module control_unit (
    input  mips_isa_pkg::opcode_t    opcode,
    input  mips_isa_pkg::funct_t     funct,
    input  cpu_ctrl_pkg::cpu_state_t state,
    input  logic                     waitrequest,
    output cpu_ctrl_pkg::ctrl_t      ctrl
);
    import mips_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic exec1;
    logic exec2;
    logic arith;   // R-type with a register result
    logic regjump; // JR

    assign exec1 = (state == EXEC1);
    assign exec2 = (state == EXEC2);

    assign arith = funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
    assign regjump = (funct == FN_JR);

    always_comb begin
        ctrl = '0; // No writes unless decoded below

        // Only a pending store holds EXEC2
        ctrl.pcwrite = exec2 && !(opcode == OP_SW && waitrequest);

        if (state == FETCH) begin
            ctrl.memread = 1'b1; // Read instruction
            ctrl.pctoadd = 1'b1; // From PC
        end else if (state == DECODE) begin
            ctrl.inwrite = 1'b1; // Capture readdata
            ctrl.pctoadd = 1'b1;
        end else if (exec1 || exec2) begin
            case (opcode)
                OP_RTYPE: begin
                    ctrl.aluop     = ALUOP_FUNCT;
                    ctrl.regdst    = 1'b1;          // Write rd
                    ctrl.jump      = regjump;
                    ctrl.regtojump = regjump;       // Target from rs
                    ctrl.regwrite  = arith && exec2;
                end
                OP_ADDIU: begin
                    ctrl.aluop    = ALUOP_ADD;
                    ctrl.alusrc   = 1'b1;
                    ctrl.regwrite = exec2;
                end
                OP_ANDI, OP_ORI, OP_XORI: begin
                    ctrl.aluop    = ALUOP_IMM;
                    ctrl.alusrc   = 1'b1;
                    ctrl.imm_zext = 1'b1; // Logic imm is unsigned
                    ctrl.regwrite = exec2;
                end
                OP_SLTIU, OP_LUI: begin
                    ctrl.aluop    = ALUOP_IMM;
                    ctrl.alusrc   = 1'b1;
                    ctrl.regwrite = exec2;
                end
                OP_BEQ: begin
                    ctrl.aluop  = ALUOP_SUB; // Zero flag on equal
                    ctrl.branch = 1'b1;
                end
                OP_BNE: begin
                    ctrl.aluop     = ALUOP_SUB;
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = 1'b1;
                end
                OP_LW: begin
                    ctrl.aluop    = ALUOP_ADD; // Base plus offset
                    ctrl.alusrc   = 1'b1;
                    ctrl.memread  = exec1;
                    ctrl.memtoreg = 1'b1;
                    ctrl.regwrite = exec2;     // Data arrives in EXEC2
                end
                OP_SW: begin
                    ctrl.aluop    = ALUOP_ADD;
                    ctrl.alusrc   = 1'b1;
                    ctrl.memwrite = exec2;
                end
                OP_J: begin
                    ctrl.jump = 1'b1;
                end
                OP_JAL: begin
                    ctrl.jump     = 1'b1;
                    ctrl.link     = 1'b1;  // Return address to r31
                    ctrl.regwrite = exec2;
                end
                default: begin
                    ctrl.aluop = ALUOP_ADD; // Unknown opcode acts as NOP
                end
            endcase
        end
    end

endmodule

// ==== hw/alu_control.sv ====
// ALU operation decoder
`timescale 1ns/1ps

module alu_control (
    input  cpu_ctrl_pkg::aluop_class_t aluop,
    input  mips_isa_pkg::opcode_t      opcode,
    input  mips_isa_pkg::funct_t       funct,
    output cpu_ctrl_pkg::alu_op_t      alu_op
);
    import mips_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    always_comb begin
        alu_op = ALU_ADD;
        case (aluop)
            ALUOP_ADD: alu_op = ALU_ADD;
            ALUOP_SUB: alu_op = ALU_SUB; // Equality test for branches
            ALUOP_FUNCT: begin
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: alu_op = ALU_ADD; // JR ignores the ALU
                endcase
            end
            ALUOP_IMM: begin
                case (opcode)
                    OP_ANDI:  alu_op = ALU_AND;
                    OP_ORI:   alu_op = ALU_OR;
                    OP_XORI:  alu_op = ALU_XOR;
                    OP_SLTIU: alu_op = ALU_SLTU;
                    OP_LUI:   alu_op = ALU_LUI;
                    default:  alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

endmodule

// ==== hw/datapath.sv ====
// Core datapath
`timescale 1ns/1ps

module datapath #(
    parameter logic [31:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cpu_ctrl_pkg::ctrl_t   ctrl,
    input  cpu_ctrl_pkg::alu_op_t alu_op,
    input  logic [31:0]           readdata,
    output mips_isa_pkg::instr_t  instr,
    output logic [31:0]           address,
    output logic [31:0]           writedata,
    output logic                  jump_zero,
    output logic [31:0]           register_v0
);
    import cpu_ctrl_pkg::*;

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;
    logic [31:0] regs [32];     // Register file, r0 never written
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        zero;
    logic        take_branch;
    logic [31:0] branch_target;
    logic [31:0] jump_target;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_VECTOR;
        end else if (ctrl.pcwrite) begin
            pc <= pc_next; // End of EXEC2
        end
    end

    // Instruction register loads in DECODE
    always_ff @(posedge clk) begin
        if (ctrl.inwrite) begin
            instr <= readdata;
        end
    end

    // Register file reads, r0 reads as zero
    assign rs_data = (instr.r_fmt.rs == 5'd0) ? 32'd0 : regs[instr.r_fmt.rs];
    assign rt_data = (instr.r_fmt.rt == 5'd0) ? 32'd0 : regs[instr.r_fmt.rt];

    always_comb begin
        if (ctrl.link) begin
            waddr = 5'd31; // JAL return register
        end else if (ctrl.regdst) begin
            waddr = instr.r_fmt.rd;
        end else begin
            waddr = instr.i_fmt.rt;
        end
    end

    always_comb begin
        if (ctrl.link) begin
            wdata = pc_plus4; // No delay slot
        end else if (ctrl.memtoreg) begin
            wdata = readdata; // LW result
        end else begin
            wdata = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.regwrite && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign register_v0 = regs[2]; // Observation port

    assign imm_ext = ctrl.imm_zext ? {16'd0, instr.i_fmt.imm}
                                   : {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
    assign alu_b = ctrl.alusrc ? imm_ext : rt_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = rs_data + alu_b;
            ALU_SUB:  alu_result = rs_data - alu_b;
            ALU_AND:  alu_result = rs_data & alu_b;
            ALU_OR:   alu_result = rs_data | alu_b;
            ALU_XOR:  alu_result = rs_data ^ alu_b;
            ALU_SLT:  alu_result = {31'd0, $signed(rs_data) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'd0, rs_data < alu_b};
            ALU_LUI:  alu_result = {alu_b[15:0], 16'd0};
            default:  alu_result = rs_data + alu_b;
        endcase
    end

    assign zero = (alu_result == 32'd0);

    // Next PC selection
    assign pc_plus4      = pc + 32'd4;
    assign take_branch   = ctrl.branch && (zero != ctrl.branch_ne);
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = ctrl.regtojump ? rs_data
                                          : {pc_plus4[31:28], instr.j_fmt.target, 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            pc_next = jump_target;
        end else if (take_branch) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    assign jump_zero = ctrl.jump && (jump_target == 32'd0); // Halt request

    // Avalon request fields
    assign address   = ctrl.pctoadd ? pc : alu_result;
    assign writedata = rt_data; // SW data

endmodule

// ==== hw/mips_cpu.sv ====
// Multicycle MIPS core top level
`timescale 1ns/1ps

module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    input  logic [31:0] readdata,
    input  logic        waitrequest,
    output logic        active,
    output logic [31:0] register_v0
);
    import mips_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    cpu_state_t state;
    ctrl_t      ctrl;
    alu_op_t    alu_op;
    instr_t     instr;
    logic       jump_zero;

    assign read  = ctrl.memread;  // Strobes straight from the decoder
    assign write = ctrl.memwrite;

    cpu_sequencer #(.RESET_VECTOR(RESET_VECTOR)) u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .memread     (ctrl.memread),
        .memwrite    (ctrl.memwrite),
        .jump_zero   (jump_zero),
        .state       (state),
        .active      (active)
    );

    control_unit u_control_unit (
        .opcode      (instr.r_fmt.opcode),
        .funct       (instr.r_fmt.funct),
        .state       (state),
        .waitrequest (waitrequest),
        .ctrl        (ctrl)
    );

    alu_control u_alu_control (
        .aluop  (ctrl.aluop),
        .opcode (instr.r_fmt.opcode),
        .funct  (instr.r_fmt.funct),
        .alu_op (alu_op)
    );

    datapath #(.RESET_VECTOR(RESET_VECTOR)) u_datapath (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl),
        .alu_op      (alu_op),
        .readdata    (readdata),
        .instr       (instr),
        .address     (address),
        .writedata   (writedata),
        .jump_zero   (jump_zero),
        .register_v0 (register_v0)
    );

endmodule

// ==== tests/avalon_mem_model.sv ====
// Avalon word memory model
`timescale 1ns/1ps

module avalon_mem_model #(
    parameter int          ADDR_BITS = 10,           // Word address width
    parameter logic [31:0] SEED      = 32'h9cad7380
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest
);
    logic [31:0]          mem [2**ADDR_BITS]; // Loaded by the testbench
    logic [ADDR_BITS-1:0] index;
    logic [ADDR_BITS-1:0] rd_index;           // Word of the accepted read
    logic                 rd_valid;           // Read accepted on the last rising edge
    integer               seed;
    logic [31:0]          rnd;

    assign index = address[ADDR_BITS+1:2]; // Upper address bits alias

    initial begin
        seed        = SEED;
        waitrequest = 1'b1;  // Stalled until the first falling edge
        readdata    = 32'd0;
        rd_valid    = 1'b0;
    end

    // New stall decision and read data on every falling edge
    always @(negedge clk) begin
        rnd = $random(seed);
        waitrequest = (rnd[3:0] < 4'd6); // Roughly three cycles in eight
        if (rd_valid) begin
            readdata = mem[rd_index]; // Valid in the cycle after acceptance
        end
    end

    // Accepted requests are taken on the rising edge
    always @(posedge clk) begin
        rd_valid <= arst_n && !waitrequest && read;
        rd_index <= index;
        if (arst_n && !waitrequest && write) begin
            mem[index] <= writedata;
        end
    end

endmodule

// ==== tests/tb_mips_cpu.sv ====
// MIPS core testbench
`timescale 1ns/1ps

module tb_mips_cpu;
    import mips_isa_pkg::*;

    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;
    localparam int          RUN_TIMEOUT  = 3000; // Cycles allowed until halt
    localparam int          QUIET_CYCLES = 50;   // Bus must stay idle after halt

    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } bus_req_t;

    logic        clk;
    logic        arst_n;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic        waitrequest;
    logic        active;
    logic [31:0] register_v0;

    logic [31:0] prog [$];      // Program words from RESET_VECTOR on
    logic [31:0] mregs [32];    // Model register file
    logic [31:0] mmem [1024];   // Model data memory
    logic [31:0] model_pc;
    logic        model_halted;
    logic        v0_written;    // Register 2 has a defined value
    logic        load_pending;  // Next accepted read is LW data
    logic [31:0] load_addr;
    logic        store_pending;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    bus_req_t    last_req;
    logic        held;          // Previous request stalled
    logic        timed_out;
    int          errors;
    int          checks;
    int          cycles;

    mips_cpu #(.RESET_VECTOR(RESET_VECTOR)) u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_mem_model #(.SEED(32'h9cad7380)) u_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    function automatic logic [31:0] rtype_word(funct_t fn, int rs, int rt, int rd);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(opcode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jump_word(opcode_t op, logic [31:0] dest);
        return {op, dest[27:2]}; // Same 256 MB region
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic build_program();
        prog.push_back(itype_word(OP_ADDIU, 0, 8, 16'h1234));
        prog.push_back(itype_word(OP_LUI, 0, 9, 16'hF000));
        prog.push_back(itype_word(OP_ORI, 9, 9, 16'h00FF));    // r9 = F00000FF
        prog.push_back(itype_word(OP_ADDIU, 0, 10, -5));
        prog.push_back(rtype_word(FN_ADDU, 8, 9, 2));
        prog.push_back(rtype_word(FN_SUBU, 8, 9, 2));
        prog.push_back(rtype_word(FN_AND, 8, 9, 2));
        prog.push_back(rtype_word(FN_OR, 8, 9, 2));
        prog.push_back(rtype_word(FN_XOR, 8, 9, 2));
        prog.push_back(rtype_word(FN_SLT, 9, 8, 2));            // Negative vs positive
        prog.push_back(rtype_word(FN_SLTU, 9, 8, 2));
        prog.push_back(itype_word(OP_ADDIU, 10, 2, 16'h7FFF));
        prog.push_back(itype_word(OP_ANDI, 9, 2, 16'hFFF0));
        prog.push_back(itype_word(OP_ORI, 8, 2, 16'hA000));
        prog.push_back(itype_word(OP_XORI, 9, 2, 16'h5555));
        prog.push_back(itype_word(OP_SLTIU, 8, 2, -1));         // Against FFFFFFFF
        prog.push_back(itype_word(OP_LUI, 0, 2, 16'hBEEF));
        prog.push_back(itype_word(OP_ADDIU, 0, 11, 16'h0200));  // Data base
        prog.push_back(rtype_word(FN_XOR, 9, 10, 12));
        prog.push_back(itype_word(OP_SW, 11, 12, 8));
        prog.push_back(itype_word(OP_ADDIU, 0, 2, 0));          // Clear before load
        prog.push_back(itype_word(OP_LW, 11, 2, 8));
        prog.push_back(itype_word(OP_BEQ, 8, 9, 2));            // Not taken
        prog.push_back(itype_word(OP_ADDIU, 0, 2, 1));
        prog.push_back(itype_word(OP_BEQ, 8, 8, 1));            // Taken
        prog.push_back(itype_word(OP_ADDIU, 0, 2, 16'h0BAD));
        prog.push_back(itype_word(OP_BNE, 8, 8, 1));            // Not taken
        prog.push_back(itype_word(OP_ADDIU, 0, 2, 2));
        prog.push_back(itype_word(OP_BNE, 8, 9, 1));            // Taken
        prog.push_back(itype_word(OP_ADDIU, 0, 2, 16'h0BAD));
        prog.push_back(jump_word(OP_J, RESET_VECTOR + 32'd128)); // Word 32
        prog.push_back(itype_word(OP_ADDIU, 0, 2, 16'h0BAD));
        prog.push_back(jump_word(OP_JAL, RESET_VECTOR + 32'd140)); // Word 35
        prog.push_back(itype_word(OP_ADDIU, 2, 2, 16'h0010));
        prog.push_back(rtype_word(FN_JR, 0, 0, 0));              // Halt
        prog.push_back(itype_word(OP_ADDIU, 0, 2, 16'h0077));   // Subroutine
        prog.push_back(rtype_word(FN_JR, 31, 0, 0));
    endtask

    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            u_mem.mem[i] = 32'd0;
            mmem[i] = 32'd0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            u_mem.mem[i] = prog[i]; // RESET_VECTOR maps to word 0
        end
    endtask

    task automatic set_reg(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) begin
            mregs[r] = v;
        end
        if (r == 5'd2) begin
            v0_written = 1'b1;
        end
    endtask

    // Executes the instruction at model_pc in one step
    task automatic model_step();
        logic [31:0] iw;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] pc4;
        logic [31:0] idx;
        idx = (model_pc - RESET_VECTOR) >> 2;
        iw = (idx < prog.size()) ? prog[idx] : 32'd0; // Outside the program acts as NOP
        a = mregs[iw[25:21]];
        b = mregs[iw[20:16]];
        simm = {{16{iw[15]}}, iw[15:0]};
        zimm = {16'd0, iw[15:0]};
        pc4 = model_pc + 32'd4;
        model_pc = pc4;
        case (iw[31:26])
            OP_RTYPE: begin
                case (iw[5:0])
                    FN_ADDU: set_reg(iw[15:11], a + b);
                    FN_SUBU: set_reg(iw[15:11], a - b);
                    FN_AND:  set_reg(iw[15:11], a & b);
                    FN_OR:   set_reg(iw[15:11], a | b);
                    FN_XOR:  set_reg(iw[15:11], a ^ b);
                    FN_SLT:  set_reg(iw[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    FN_SLTU: set_reg(iw[15:11], (a < b) ? 32'd1 : 32'd0);
                    FN_JR:   model_pc = a;
                    default: ;
                endcase
            end
            OP_ADDIU: set_reg(iw[20:16], a + simm);
            OP_SLTIU: set_reg(iw[20:16], (a < simm) ? 32'd1 : 32'd0);
            OP_ANDI:  set_reg(iw[20:16], a & zimm);
            OP_ORI:   set_reg(iw[20:16], a | zimm);
            OP_XORI:  set_reg(iw[20:16], a ^ zimm);
            OP_LUI:   set_reg(iw[20:16], {iw[15:0], 16'd0});
            OP_BEQ: begin
                if (a == b) begin
                    model_pc = pc4 + (simm << 2);
                end
            end
            OP_BNE: begin
                if (a != b) begin
                    model_pc = pc4 + (simm << 2);
                end
            end
            OP_LW: begin
                load_pending = 1'b1;
                load_addr = a + simm;
                set_reg(iw[20:16], mmem[load_addr[11:2]]);
            end
            OP_SW: begin
                store_pending = 1'b1;
                store_addr = a + simm;
                store_data = b;
                mmem[store_addr[11:2]] = b;
            end
            OP_J:   model_pc = {pc4[31:28], iw[25:0], 2'b00};
            OP_JAL: begin
                set_reg(5'd31, pc4); // No delay slot
                model_pc = {pc4[31:28], iw[25:0], 2'b00};
            end
            default: ;
        endcase
        if (model_pc == 32'd0) begin
            model_halted = 1'b1;
        end
    endtask

    // Bus monitor, sampled before the edge updates
    always @(posedge clk) begin
        if (arst_n) begin
            checks++;
            assert (!(read && write)) else log_error("read and write high together");
            if (held) begin
                checks++;
                assert (address == last_req.address && read == last_req.read
                        && write == last_req.write
                        && (!write || writedata == last_req.writedata))
                    else log_error("request changed while waitrequest was high");
            end
            if (!active) begin
                checks++;
                assert (!read && !write) else log_error("bus request after halt");
            end
            if (read && !waitrequest) begin
                if (load_pending) begin
                    checks++;
                    assert (address == load_addr)
                        else log_error($sformatf("LW address %h, expected %h",
                                                 address, load_addr));
                    load_pending = 1'b0;
                end else begin
                    checks += 2;
                    assert (address == model_pc && !model_halted)
                        else log_error($sformatf("fetch from %h, expected %h",
                                                 address, model_pc));
                    assert (!v0_written || register_v0 == mregs[2])
                        else log_error($sformatf("register_v0 %h, expected %h",
                                                 register_v0, mregs[2]));
                    model_step();
                end
            end
            if (write && !waitrequest) begin
                checks++;
                assert (store_pending && address == store_addr && writedata == store_data)
                    else log_error($sformatf("write %h to %h, expected %h to %h",
                                             writedata, address, store_data, store_addr));
                store_pending = 1'b0;
            end
            held = (read || write) && waitrequest;
            last_req = {address, read, write, writedata};
        end
    end

    initial begin
        arst_n = 1'b0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        model_pc = RESET_VECTOR;
        model_halted = 1'b0;
        v0_written = 1'b0;
        load_pending = 1'b0;
        store_pending = 1'b0;
        held = 1'b0;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = 32'd0;
        end
        build_program();
        load_program();
        repeat (3) begin // First fetch waits at RESET_VECTOR
            @(negedge clk);
            checks++;
            assert (!write && active && address == RESET_VECTOR)
                else log_error($sformatf("reset state: write %b active %b address %h",
                                         write, active, address));
        end
        arst_n = 1'b1; // Released on the falling edge
        cycles = 0;
        while (active && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            timed_out = 1'b1;
            $display("Timeout: core still running after %0d cycles", RUN_TIMEOUT);
        end else begin
            repeat (QUIET_CYCLES) @(negedge clk); // Monitor watches the idle bus
            checks += 2;
            assert (model_halted) else log_error("core halted before the model did");
            assert (register_v0 == mregs[2])
                else log_error($sformatf("final register_v0 %h, expected %h",
                                         register_v0, mregs[2]));
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== mips_cpu.f ====
hw/mips_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/cpu_sequencer.sv
hw/control_unit.sv
hw/alu_control.sv
hw/datapath.sv
hw/mips_cpu.sv
tests/avalon_mem_model.sv
tests/tb_mips_cpu.sv

// ==== Bender.yml ====
package:
  name: mips_cpu

sources:
  - files:
      - hw/mips_isa_pkg.sv
      - hw/cpu_ctrl_pkg.sv
      - hw/cpu_sequencer.sv
      - hw/control_unit.sv
      - hw/alu_control.sv
      - hw/datapath.sv
      - hw/mips_cpu.sv
  - target: test
    files:
      - tests/avalon_mem_model.sv
      - tests/tb_mips_cpu.sv
